// ==== logic/fpFormatPkg.sv ====
// Single-precision layout only, subnormal encodings are classed as zero and never produced
package fpFormatPkg;

    // IEEE-754 binary32 word
    typedef struct packed
    {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] fraction;
    } fpWord;

    // Operand kinds seen by the datapath
    typedef enum logic [1:0]
    {
        clsZero   = 2'd0,    // Also covers flushed subnormals
        clsNormal = 2'd1,
        clsInf    = 2'd2,
        clsNaN    = 2'd3
    } fpClass;

    // Supported operations
    typedef enum logic
    {
        opAdd = 1'b0,
        opSub = 1'b1
    } fpOp;

    // All-ones exponent marks infinity and NaN
    localparam logic [7:0] expMax = 8'd255;

    // Result of invalid operations such as inf - inf
    localparam fpWord canonicalNaN = '{
        sign:     1'b0,
        exponent: 8'hff,
        fraction: 23'h7fffff
    };

endpackage

// ==== logic/fpAdderStagePkg.sv ====
// Stage records assume the binary32 layout, and field b carries B with the opcode already applied
package fpAdderStagePkg;

    import fpFormatPkg::*;

    // Output of the alignment stage
    typedef struct packed
    {
        logic        valid;
        fpWord       a;
        fpWord       b;            // Sign reflects subtract
        fpClass      classA;
        fpClass      classB;
        logic        signLarge;
        logic        signSmall;
        logic [7:0]  exponentOut;  // Exponent of the larger operand
        logic [23:0] mantLarge;    // Hidden bit included
        logic [23:0] mantSmall;    // Already shifted right
        logic        guardBit;
        logic        roundBit;
        logic        stickyBit;
        logic        effSub;
    } alignedPair;

    // Output of the significand adder
    typedef struct packed
    {
        logic        valid;
        fpWord       a;
        fpWord       b;
        fpClass      classA;
        fpClass      classB;
        logic        alignedSign;
        logic [7:0]  exponentOut;
        logic [23:0] alignedResult;
        logic        carryOut;
        logic        guardBit;
        logic        roundBit;
        logic        stickyBit;
        logic        exactZero;    // Subtraction cancelled to zero
    } sumResult;

endpackage

// ==== logic/fpAlign.sv ====
// Subnormal operands are flushed to zero here and B leaves this stage with the opcode folded in
`timescale 1ns/1ps

module fpAlign
    import fpFormatPkg::*;
    import fpAdderStagePkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       inValid,
    input  fpOp        op,
    input  fpWord      a,
    input  fpWord      b,
    output alignedPair aligned
);

    fpClass      classA;
    fpClass      classB;
    fpWord       effB;
    logic [7:0]  expA, expB;
    logic [23:0] mantA, mantB;
    logic        aLarger;
    logic [7:0]  expDiff;
    logic [23:0] mantSmallRaw;
    logic [49:0] shiftedExt;
    alignedPair  nextPair;

    function automatic fpClass classify(input fpWord w);
        fpClass kind;
        if (w.exponent == 8'd0)
            kind = clsZero;
        else if (w.exponent == expMax)
            kind = (w.fraction != 23'd0) ? clsNaN : clsInf;
        else
            kind = clsNormal;
        return kind;
    endfunction

    always_comb
    begin
        classA = classify(a);
        classB = classify(b);

        // Subtract is an add with B negated
        effB = b;
        effB.sign = b.sign ^ (op == opSub);

        // Zero class drops exponent and hidden bit
        expA  = (classA == clsZero) ? 8'd0  : a.exponent;
        expB  = (classB == clsZero) ? 8'd0  : b.exponent;
        mantA = (classA == clsZero) ? 24'd0 : {1'b1, a.fraction};
        mantB = (classB == clsZero) ? 24'd0 : {1'b1, b.fraction};

        aLarger = {expA, mantA[22:0]} >= {expB, mantB[22:0]};   // Ties keep A on top

        expDiff      = aLarger ? (expA - expB) : (expB - expA);
        mantSmallRaw = aLarger ? mantB : mantA;

        nextPair.valid       = inValid;
        nextPair.a           = a;
        nextPair.b           = effB;
        nextPair.classA      = classA;
        nextPair.classB      = classB;
        nextPair.signLarge   = aLarger ? a.sign : effB.sign;
        nextPair.signSmall   = aLarger ? effB.sign : a.sign;
        nextPair.exponentOut = aLarger ? expA : expB;
        nextPair.mantLarge   = aLarger ? mantA : mantB;
        nextPair.effSub      = a.sign ^ effB.sign;

        // 26 spare bits hold every shifted-out bit up to a shift of 26
        shiftedExt = {mantSmallRaw, 26'd0} >> expDiff;
        if (expDiff > 8'd26)
        begin
            // Whole significand sits below the round bit
            nextPair.mantSmall = 24'd0;
            nextPair.guardBit  = 1'b0;
            nextPair.roundBit  = 1'b0;
            nextPair.stickyBit = |mantSmallRaw;
        end
        else
        begin
            nextPair.mantSmall = shiftedExt[49:26];
            nextPair.guardBit  = shiftedExt[25];
            nextPair.roundBit  = shiftedExt[24];
            nextPair.stickyBit = |shiftedExt[23:0];
        end
    end

    always_ff @(posedge clk)
    begin
        aligned <= nextPair;
        if (!rstN)
            aligned.valid <= 1'b0;
    end

endmodule

// ==== logic/fpSignificandAdd.sv ====
// Relies on the alignment stage ordering operands by magnitude so a subtraction never goes negative
`timescale 1ns/1ps

module fpSignificandAdd
    import fpAdderStagePkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  alignedPair aligned,
    output sumResult   sum
);

    logic [26:0] extLarge;
    logic [26:0] extSmall;
    logic [27:0] extSum;
    logic        cancelled;
    sumResult    nextSum;

    always_comb
    begin
        // Larger operand has no bits below its significand
        extLarge = {aligned.mantLarge, 3'b000};
        extSmall = {aligned.mantSmall, aligned.guardBit, aligned.roundBit, aligned.stickyBit};

        if (aligned.effSub)
            extSum = {1'b0, extLarge} - {1'b0, extSmall};
        else
            extSum = {1'b0, extLarge} + {1'b0, extSmall};

        cancelled = aligned.effSub && (extSum == 28'd0);

        nextSum.valid         = aligned.valid;
        nextSum.a             = aligned.a;
        nextSum.b             = aligned.b;
        nextSum.classA        = aligned.classA;
        nextSum.classB        = aligned.classB;
        nextSum.exponentOut   = aligned.exponentOut;
        nextSum.alignedResult = extSum[26:3];
        nextSum.carryOut      = extSum[27];   // Only an add can set this
        nextSum.guardBit      = extSum[2];
        nextSum.roundBit      = extSum[1];
        nextSum.stickyBit     = extSum[0];
        nextSum.exactZero     = cancelled;

        // Exact cancellation yields +0
        nextSum.alignedSign = cancelled ? 1'b0 : aligned.signLarge;
    end

    always_ff @(posedge clk)
    begin
        sum <= nextSum;
        if (!rstN)
            sum.valid <= 1'b0;
    end

endmodule

// ==== logic/fpNormalize.sv ====
// Round to nearest even only, results below the smallest normal flush to signed zero
`timescale 1ns/1ps

module fpNormalize
    import fpFormatPkg::*;
    import fpAdderStagePkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  sumResult sum,
    output logic     outValid,
    output fpWord    result
);

    logic [4:0]         zeroCount;
    logic [26:0]        shiftedExt;
    logic [23:0]        normMant;
    logic               guard, round, sticky;
    logic               roundUp;
    logic [24:0]        roundedMant;
    logic signed [9:0]  normExp;
    logic signed [9:0]  finalExp;
    fpWord              nextResult;

    // Leading zeros of a 24-bit significand, 24 when empty
    function automatic logic [4:0] countZeros(input logic [23:0] mant);
        logic [4:0] count;
        count = 5'd24;
        for (int i = 0; i < 24; i++)
            if (mant[i])
                count = 5'(23 - i);   // Highest set bit wins
        return count;
    endfunction

    always_comb
    begin
        zeroCount   = countZeros(sum.alignedResult);
        shiftedExt  = 27'd0;
        normMant    = 24'd0;
        guard       = 1'b0;
        round       = 1'b0;
        sticky      = 1'b0;
        normExp     = 10'sd0;
        roundUp     = 1'b0;
        roundedMant = 25'd0;
        finalExp    = 10'sd0;

        if (sum.carryOut)
        begin
            // One place right, old LSB becomes guard
            normMant = {1'b1, sum.alignedResult[23:1]};
            guard    = sum.alignedResult[0];
            round    = sum.guardBit;
            sticky   = sum.roundBit | sum.stickyBit;
            normExp  = 10'(sum.exponentOut) + 10'sd1;
        end
        else
        begin
            shiftedExt = {sum.alignedResult, sum.guardBit, sum.roundBit, sum.stickyBit}
                         << zeroCount;
            normMant   = shiftedExt[26:3];
            guard      = shiftedExt[2];
            round      = shiftedExt[1];
            sticky     = shiftedExt[0];
            normExp    = 10'(sum.exponentOut) - 10'(zeroCount);
        end

        // Ties go to the even significand
        roundUp     = guard & (round | sticky | normMant[0]);
        roundedMant = {1'b0, normMant} + 25'(roundUp);
        finalExp    = roundedMant[24] ? (normExp + 10'sd1) : normExp;

        if (sum.classA == clsNaN)
            nextResult = sum.a;
        else if (sum.classB == clsNaN)
            nextResult = sum.b;
        else if (sum.classA == clsInf && sum.classB == clsInf)
            nextResult = (sum.a.sign != sum.b.sign) ? canonicalNaN : sum.a;
        else if (sum.classA == clsInf)
            nextResult = sum.a;
        else if (sum.classB == clsInf)
            nextResult = sum.b;
        else if (sum.exactZero || (sum.alignedResult == 24'd0 && !sum.carryOut))
            nextResult = '{sign: sum.alignedSign, exponent: 8'd0, fraction: 23'd0};
        else if (finalExp >= 10'sd255)
        begin
            // Overflow to signed infinity
            nextResult = '{sign: sum.alignedSign, exponent: expMax, fraction: 23'd0};
        end
        else if (finalExp <= 10'sd0)
            nextResult = '{sign: sum.alignedSign, exponent: 8'd0, fraction: 23'd0};  // Flush
        else
        begin
            nextResult.sign     = sum.alignedSign;
            nextResult.exponent = finalExp[7:0];
            // Rounding carry leaves 1.000, so these bits are already zero
            nextResult.fraction = roundedMant[22:0];
        end
    end

    always_ff @(posedge clk)
    begin
        result <= nextResult;
        if (!rstN)
            outValid <= 1'b0;
        else
            outValid <= sum.valid;
    end

endmodule

// ==== logic/fpAdder.sv ====
// Three-cycle latency with no back-pressure, so each result must be taken when outValid is high
`timescale 1ns/1ps

module fpAdder
    import fpFormatPkg::*;
    import fpAdderStagePkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  logic  inValid,
    input  fpOp   op,
    input  fpWord a,
    input  fpWord b,
    output logic  outValid,
    output fpWord result
);

    alignedPair alignedStage;   // Stage 1 to stage 2
    sumResult   sumStage;       // Stage 2 to stage 3

    // Unpack, order and align
    fpAlign alignStage (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (inValid),
        .op      (op),
        .a       (a),
        .b       (b),
        .aligned (alignedStage)
    );

    fpSignificandAdd addStage (
        .clk     (clk),
        .rstN    (rstN),
        .aligned (alignedStage),
        .sum     (sumStage)
    );

    // Renormalize, round and resolve specials
    fpNormalize normStage (
        .clk      (clk),
        .rstN     (rstN),
        .sum      (sumStage),
        .outValid (outValid),
        .result   (result)
    );

endmodule

// ==== verif/fpAdder_assert.sv ====
// Bound to fpAdder, assumes inputs are meaningful only while inValid is high and results lag by three edges
`timescale 1ns/1ps

module fpAdderAssert
    import fpFormatPkg::*;
(
    input logic  clk,
    input logic  rstN,
    input logic  inValid,
    input fpOp   op,
    input fpWord a,
    input fpWord b,
    input logic  outValid,
    input fpWord result
);

    int   failCount = 0;
    logic aNaN, bNaN, infClash, nanCause;

    assign aNaN     = (a.exponent == expMax) && (a.fraction != 23'd0);
    assign bNaN     = (b.exponent == expMax) && (b.fraction != 23'd0);
    // Opposite infinities once the opcode is folded into B
    assign infClash = (a.exponent == expMax) && (a.fraction == 23'd0)
                      && (b.exponent == expMax) && (b.fraction == 23'd0)
                      && (a.sign ^ b.sign ^ (op == opSub));
    assign nanCause = inValid && (aNaN || bNaN || infClash);

    latencyMatch: assert property (@(posedge clk) disable iff (!rstN)
        outValid == $past(inValid, 3))
    else
    begin
        $error("outValid does not follow inValid by three cycles");
        failCount++;
    end

    quietInReset: assert property (@(posedge clk) !rstN |=> !outValid)
    else
    begin
        $error("outValid high while reset is applied");
        failCount++;
    end

    resultKnown: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> !$isunknown(result))
    else
    begin
        $error("Result has unknown bits while outValid is high");
        failCount++;
    end

    nanHasCause: assert property (@(posedge clk) disable iff (!rstN)
        (outValid && result.exponent == expMax && result.fraction != 23'd0)
        |-> $past(nanCause, 3))
    else
    begin
        $error("NaN result without a NaN operand or clashing infinities");
        failCount++;
    end

endmodule

bind fpAdder fpAdderAssert fpAdderAssertInst (.*);

// ==== verif/fpAdderChecker.sv ====
// Results must come back in issue order, each is matched to the operation recorded when it went in
`timescale 1ns/1ps

module fpAdderChecker
    import fpFormatPkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  logic  inValid,
    input  fpOp   op,
    input  fpWord a,
    input  fpWord b,
    input  fpWord expected,
    input  logic  checkValue,     // Compare against expected
    input  logic  commuteFirst,   // Remember result of a + b
    input  logic  commuteSecond,  // Must match the remembered result
    input  logic  outValid,
    input  fpWord result,
    output int    valueErrors,
    output int    timingErrors,
    output int    pending
);

    typedef struct packed
    {
        int    issueCycle;
        fpOp   op;
        fpWord a;
        fpWord b;
        fpWord expected;
        logic  checkValue;
        logic  commuteFirst;
        logic  commuteSecond;
    } issuedOp;

    issuedOp inFlight[$];
    issuedOp entry;
    int      cycleCount = 0;
    int      pushCount = 0;
    int      popCount = 0;
    int      latency;
    fpWord   firstOrder;

    initial
    begin
        valueErrors  = 0;
        timingErrors = 0;
    end

    assign pending = pushCount - popCount;

    // Inputs are stable here, they change on the falling edge
    always @(posedge clk)
    begin
        cycleCount++;
        if (rstN && inValid)
        begin
            inFlight.push_back('{cycleCount, op, a, b, expected,
                                 checkValue, commuteFirst, commuteSecond});
            pushCount++;
        end
    end

    // Outputs settle after the rising edge
    always @(negedge clk)
    begin
        if (outValid === 1'b1)
        begin
            if (inFlight.size() == 0)
            begin
                $display("Unexpected result %h at %0t with no operation in flight",
                         result, $time);
                timingErrors++;
            end
            else
            begin
                entry = inFlight.pop_front();
                popCount++;
                // Counted up to the next rising edge, which samples this result
                latency = cycleCount + 1 - entry.issueCycle;
                if (latency != 3)
                begin
                    $display("Result for a=%h b=%h came %0d cycles after its input, not 3",
                             entry.a, entry.b, latency);
                    timingErrors++;
                end
                if (entry.checkValue && result !== entry.expected)
                begin
                    $display("ERROR at %0t: %s a=%h b=%h expected %h observed %h",
                             $time, entry.op.name(), entry.a, entry.b, entry.expected, result);
                    valueErrors++;
                end
                if (entry.commuteFirst)
                    firstOrder = result;
                if (entry.commuteSecond && result !== firstOrder)
                begin
                    $display("ERROR at %0t: b + a for a=%h b=%h gave %h but a + b gave %h",
                             $time, entry.b, entry.a, result, firstOrder);
                    valueErrors++;
                end
            end
        end
    end

endmodule

// ==== verif/fpAdderTb.sv ====
// Table results are worked out by hand, random pairs are only checked for latency and a + b == b + a
`timescale 1ns/1ps

module fpAdderTb
    import fpFormatPkg::*;
();

    typedef struct packed
    {
        fpOp   op;
        fpWord a;
        fpWord b;
        fpWord expected;
    } vectorEntry;

    localparam int randomPairs = 40;
    localparam int drainLimit  = 50;   // Cycles allowed for the pipeline to empty

    logic       clk;
    logic       rstN;
    logic       inValid;
    fpOp        op;
    fpWord      a;
    fpWord      b;
    fpWord      expected;
    logic       checkValue, commuteFirst, commuteSecond;
    logic       outValid;
    fpWord      result;
    int         valueErrors, timingErrors, pending;
    int         missingResults;
    vectorEntry vectors[$];

    fpAdder dut (.*);

    fpAdderChecker resultCheck (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic addVector(input fpOp opIn, input fpWord aIn, bIn, expIn);
        vectors.push_back('{opIn, aIn, bIn, expIn});
    endtask

    task automatic loadVectors();
        addVector(opAdd, 32'h3fc00000, 32'h3fc00000, 32'h40400000);  // 1.5 + 1.5, carry out
        addVector(opAdd, 32'h3f800000, 32'h40000000, 32'h40400000);
        addVector(opSub, 32'h40a00000, 32'h40400000, 32'h40000000);  // 5 - 3
        addVector(opSub, 32'h3f800000, 32'h40000000, 32'hbf800000);
        addVector(opAdd, 32'hc0200000, 32'hbfa00000, 32'hc0700000);
        // Rounding, B sits one ulp or less below A
        addVector(opAdd, 32'h3f800000, 32'h33800000, 32'h3f800000);  // Tie stays even
        addVector(opAdd, 32'h3f800001, 32'h33800000, 32'h3f800002);  // Tie goes up to even
        addVector(opAdd, 32'h3f800000, 32'h33c00000, 32'h3f800001);  // Above half
        addVector(opAdd, 32'h3f800000, 32'h33000000, 32'h3f800000);  // Below half
        addVector(opAdd, 32'h3fffffff, 32'h33800000, 32'h40000000);  // Carries into exponent
        // Cancellation
        addVector(opSub, 32'h40490fdb, 32'h40490fdb, 32'h00000000);
        addVector(opAdd, 32'hc0490fdb, 32'h40490fdb, 32'h00000000);
        addVector(opSub, 32'h3f800001, 32'h3f800000, 32'h34000000);  // 23-place left shift
        addVector(opSub, 32'h3fc00000, 32'h3fa00000, 32'h3e800000);
        // Specials
        addVector(opAdd, 32'h7fc00000, 32'h3f800000, 32'h7fc00000);
        addVector(opAdd, 32'h3f800000, 32'h7fc12345, 32'h7fc12345);
        addVector(opAdd, 32'h7fc00001, 32'hffc00002, 32'h7fc00001);  // A wins
        addVector(opAdd, 32'h7f800000, 32'h7f800000, 32'h7f800000);
        addVector(opSub, 32'h7f800000, 32'h7f800000, canonicalNaN);
        addVector(opAdd, 32'hff800000, 32'h7f800000, canonicalNaN);
        addVector(opAdd, 32'hff800000, 32'h3f800000, 32'hff800000);
        addVector(opSub, 32'h3f800000, 32'h7f800000, 32'hff800000);
        addVector(opAdd, 32'h00400000, 32'h3f800000, 32'h3f800000);  // Subnormal as zero
        addVector(opAdd, 32'h80400000, 32'h80000001, 32'h80000000);
        // Range limits
        addVector(opAdd, 32'h7f7fffff, 32'h7f7fffff, 32'h7f800000);
        addVector(opAdd, 32'hff7fffff, 32'hff7fffff, 32'hff800000);
        addVector(opSub, 32'h00800001, 32'h00800000, 32'h00000000);
        addVector(opSub, 32'h00800000, 32'h00800001, 32'h80000000);
    endtask

    task automatic applyOp(input fpOp opIn, input fpWord aIn, bIn, expIn,
                           input logic checkIn, firstIn, secondIn);
        @(negedge clk);
        inValid       = 1'b1;
        op            = opIn;
        a             = aIn;
        b             = bIn;
        expected      = expIn;
        checkValue    = checkIn;
        commuteFirst  = firstIn;
        commuteSecond = secondIn;
    endtask

    task automatic idleCycle();
        @(negedge clk);
        inValid       = 1'b0;
        checkValue    = 1'b0;
        commuteFirst  = 1'b0;
        commuteSecond = 1'b0;
    endtask

    function automatic fpWord randomNormal();
        fpWord w;
        w.sign     = $urandom & 1;
        w.exponent = 8'(1 + ($urandom % 254));
        w.fraction = 23'($urandom);
        return w;
    endfunction

    initial
    begin
        fpWord x;
        fpWord y;
        int    waited;
        int    totalErrors;

        void'($urandom(32'h22a17e5b));
        rstN           = 1'b0;
        inValid        = 1'b0;
        op             = opAdd;
        a              = '0;
        b              = '0;
        expected       = '0;
        checkValue     = 1'b0;
        commuteFirst   = 1'b0;
        commuteSecond  = 1'b0;
        missingResults = 0;

        repeat (4) @(negedge clk);
        rstN = 1'b1;
        idleCycle();

        loadVectors();
        foreach (vectors[i])
            applyOp(vectors[i].op, vectors[i].a, vectors[i].b, vectors[i].expected,
                    1'b1, 1'b0, 1'b0);
        idleCycle();

        // Swapped pairs back to back, random gaps between pairs
        for (int i = 0; i < randomPairs; i++)
        begin
            x = randomNormal();
            y = randomNormal();
            applyOp(opAdd, x, y, '0, 1'b0, 1'b1, 1'b0);
            applyOp(opAdd, y, x, '0, 1'b0, 1'b0, 1'b1);
            repeat ($urandom % 3) idleCycle();
        end
        idleCycle();

        waited = 0;
        while (pending != 0 && waited < drainLimit)
        begin
            @(posedge clk);
            waited++;
        end
        if (pending != 0)
        begin
            $display("Timeout: %0d results never arrived", pending);
            missingResults = pending;
        end

        totalErrors = valueErrors + timingErrors + missingResults
                      + dut.fpAdderAssertInst.failCount;
        $display("Errors: value %0d, timing %0d, missing %0d, assertion %0d",
                 valueErrors, timingErrors, missingResults, dut.fpAdderAssertInst.failCount);
        if (totalErrors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== project.f ====
logic/fpFormatPkg.sv
logic/fpAdderStagePkg.sv
logic/fpAlign.sv
logic/fpSignificandAdd.sv
logic/fpNormalize.sv
logic/fpAdder.sv
verif/fpAdder_assert.sv
verif/fpAdderChecker.sv
verif/fpAdderTb.sv

// ==== Bender.yml ====
package:
  name: fp_adder

sources:
  # Packages first, the stages import them
  - logic/fpFormatPkg.sv
  - logic/fpAdderStagePkg.sv
  - logic/fpAlign.sv
  - logic/fpSignificandAdd.sv
  - logic/fpNormalize.sv
  - logic/fpAdder.sv

  - target: test
    files:
      - verif/fpAdder_assert.sv
      - verif/fpAdderChecker.sv
      - verif/fpAdderTb.sv
